// File: Bender.yml
package:
  name: task_unit

sources:
  - task_unit_pkg.sv
  - task_fifo.sv
  - task_dispatch.sv
  - task_unit_regs.sv
  - task_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_task_unit.sv

// File: task_dispatch.sv
`timescale 1ns/1ps

module task_dispatch (
   input  logic                                   clk,
   input  logic                                   rstn,
   input  task_unit_pkg::task_t                   head,
   input  logic                                   empty,
   input  logic                                   almost_full,
   input  logic [task_unit_pkg::SPILL_SIZE_W-1:0] spill_size,

   output logic                                   overflow_valid,
   input  logic                                   overflow_ready,
   output task_unit_pkg::task_t                   overflow_data,

   output logic                                   task_deq_valid,
   input  logic                                   task_deq_ready,
   output task_unit_pkg::task_t                   task_deq_data,

   output logic                                   splitter_deq_valid,
   input  logic                                   splitter_deq_ready,
   output task_unit_pkg::task_t                   splitter_deq_task,

   output logic                                   pop
);
   import task_unit_pkg::*;

   logic [SPILL_SIZE_W-1:0] spills_remaining;
   logic                    spilling;
   logic                    is_splitter;
   logic                    overflow_fire;
   logic                    deq_fire;
   logic                    splitter_fire;

   assign spilling    = (spills_remaining != '0);
   assign is_splitter = (head.ttype == TASK_TYPE_SPLITTER);

   // Spill counter loads once the queue crosses the threshold
   always_ff @(posedge clk) begin
      if (!rstn) begin
         spills_remaining <= '0;
      end else if (!spilling && almost_full) begin
         spills_remaining <= spill_size;
      end else if (overflow_fire) begin
         spills_remaining <= spills_remaining - 1'b1;
      end
   end

   // Head goes to exactly one port
   always_comb begin
      overflow_valid     = 1'b0;
      task_deq_valid     = 1'b0;
      splitter_deq_valid = 1'b0;
      if (!empty) begin
         if (spilling) begin
            overflow_valid = 1'b1;
         end else if (is_splitter) begin
            splitter_deq_valid = 1'b1;
         end else begin
            task_deq_valid = 1'b1;
         end
      end
   end

   assign overflow_data     = head;
   assign task_deq_data     = head;
   assign splitter_deq_task = head;

   assign overflow_fire = overflow_valid & overflow_ready;
   assign deq_fire      = task_deq_valid & task_deq_ready;
   assign splitter_fire = splitter_deq_valid & splitter_deq_ready;

   // Nothing leaves the FIFO under back-pressure
   assign pop = overflow_fire | deq_fire | splitter_fire;

   assert property (@(posedge clk) disable iff (!rstn)
      overflow_valid && !overflow_ready |=> overflow_valid && $stable(overflow_data))
      else $error("task_dispatch: overflow task changed under back-pressure");

endmodule

// File: task_fifo.sv
`timescale 1ns/1ps

module task_fifo #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 wr_en,
   input  task_unit_pkg::task_t wr_data,
   input  logic                 rd_en,
   output task_unit_pkg::task_t rd_data,
   output logic                 full,
   output logic                 empty,
   output logic [LOG_DEPTH:0]   count
);
   import task_unit_pkg::*;

   localparam int DEPTH = 1 << LOG_DEPTH;

   logic [TASK_W-1:0]    mem [DEPTH];
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH-1:0] rd_ptr;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Show-ahead head
   assign rd_data = task_t'(mem[rd_ptr]);

   assign full  = (count == (LOG_DEPTH+1)'(DEPTH));
   assign empty = (count == '0);

   assert property (@(posedge clk) disable iff (!rstn) wr_en |-> !full)
      else $error("task_fifo: write while full");

   assert property (@(posedge clk) disable iff (!rstn) rd_en |-> !empty)
      else $error("task_fifo: read while empty");

endmodule

// File: task_unit.sv
`timescale 1ns/1ps

module task_unit #(
   parameter int LOG_DEPTH             = 3,
   parameter int SPILL_THRESHOLD_RESET = 5
) (
   input  logic                    clk,
   input  logic                    rstn,

   // Tile enqueue
   input  logic                    task_enq_valid,
   output logic                    task_enq_ready,
   input  task_unit_pkg::task_t    task_enq_data,

   // Coalescer children
   input  logic                    coal_child_valid,
   output logic                    coal_child_ready,
   input  task_unit_pkg::task_t    coal_child_data,

   // Overflow to coalescer
   output logic                    overflow_valid,
   input  logic                    overflow_ready,
   output task_unit_pkg::task_t    overflow_data,

   // Commit queue dequeue
   output logic                    task_deq_valid,
   input  logic                    task_deq_ready,
   output task_unit_pkg::task_t    task_deq_data,

   // Splitter
   output logic                    splitter_deq_valid,
   input  logic                    splitter_deq_ready,
   output task_unit_pkg::task_t    splitter_deq_task,

   output logic                    full,
   output logic                    almost_full,
   output logic                    empty,

   input  task_unit_pkg::reg_req_t reg_req,
   output task_unit_pkg::reg_rsp_t reg_rsp
);
   import task_unit_pkg::*;

   logic                    fifo_wr_en;
   task_t                   fifo_wr_data;
   logic                    fifo_rd_en;
   task_t                   fifo_head;
   logic [LOG_DEPTH:0]      n_tasks;
   logic [LOG_DEPTH:0]      spill_threshold;
   logic [SPILL_SIZE_W-1:0] spill_size;

   logic enq_fire;
   logic coal_fire;
   logic deq_fire;
   logic splitter_fire;
   logic overflow_fire;

   // Children win over tile enqueues
   assign coal_child_ready = coal_child_valid & ~full;
   assign task_enq_ready   = task_enq_valid & ~coal_child_ready & ~almost_full;

   assign coal_fire     = coal_child_valid & coal_child_ready;
   assign enq_fire      = task_enq_valid & task_enq_ready;
   assign deq_fire      = task_deq_valid & task_deq_ready;
   assign splitter_fire = splitter_deq_valid & splitter_deq_ready;
   assign overflow_fire = overflow_valid & overflow_ready;

   assign fifo_wr_en   = coal_fire | enq_fire;
   assign fifo_wr_data = coal_child_ready ? coal_child_data : task_enq_data;

   assign almost_full = (n_tasks > spill_threshold);

   task_fifo #(
      .LOG_DEPTH (LOG_DEPTH)
   ) task_fifo_i (
      .clk     (clk),
      .rstn    (rstn),
      .wr_en   (fifo_wr_en),
      .wr_data (fifo_wr_data),
      .rd_en   (fifo_rd_en),
      .rd_data (fifo_head),
      .full    (full),
      .empty   (empty),
      .count   (n_tasks)
   );

   task_dispatch task_dispatch_i (
      .clk                (clk),
      .rstn               (rstn),
      .head               (fifo_head),
      .empty              (empty),
      .almost_full        (almost_full),
      .spill_size         (spill_size),
      .overflow_valid     (overflow_valid),
      .overflow_ready     (overflow_ready),
      .overflow_data      (overflow_data),
      .task_deq_valid     (task_deq_valid),
      .task_deq_ready     (task_deq_ready),
      .task_deq_data      (task_deq_data),
      .splitter_deq_valid (splitter_deq_valid),
      .splitter_deq_ready (splitter_deq_ready),
      .splitter_deq_task  (splitter_deq_task),
      .pop                (fifo_rd_en)
   );

   task_unit_regs #(
      .SPILL_THRESHOLD_RESET (SPILL_THRESHOLD_RESET),
      .LOG_DEPTH             (LOG_DEPTH)
   ) task_unit_regs_i (
      .clk             (clk),
      .rstn            (rstn),
      .reg_req         (reg_req),
      .reg_rsp         (reg_rsp),
      .n_tasks         (n_tasks),
      .enq_fire        (enq_fire),
      .coal_fire       (coal_fire),
      .deq_fire        (deq_fire),
      .splitter_fire   (splitter_fire),
      .overflow_fire   (overflow_fire),
      .deq_valid       (task_deq_valid),
      .spill_threshold (spill_threshold),
      .spill_size      (spill_size)
   );

endmodule

// File: task_unit_pkg.sv
package task_unit_pkg;

   // Task kinds carried in the ttype field
   typedef enum logic [3:0] {
      TASK_TYPE_WORK     = 4'd0,
      TASK_TYPE_SPILLED  = 4'd1,
      TASK_TYPE_SPLITTER = 4'd2
   } task_type_e;

   typedef struct packed {
      task_type_e  ttype;
      logic [31:0] ts;
      logic [31:0] locale;
      logic [31:0] args;
   } task_t;

   localparam int TASK_W = $bits(task_t);

   // Register map
   typedef enum logic [7:0] {
      REG_SPILL_THRESHOLD          = 8'h00,
      REG_SPILL_SIZE               = 8'h04,
      REG_N_TASKS                  = 8'h08,
      REG_STAT_N_ENQ               = 8'h10,
      REG_STAT_N_DEQ               = 8'h14,
      REG_STAT_N_SPLITTER_DEQ      = 8'h18,
      REG_STAT_N_COAL_CHILD        = 8'h1c,
      REG_STAT_N_OVERFLOW          = 8'h20,
      REG_STAT_N_CYCLES_DEQ_VALID  = 8'h24
   } reg_addr_e;

   typedef struct packed {
      logic        wvalid;
      reg_addr_e   waddr;
      logic [31:0] wdata;
      logic        arvalid;
      reg_addr_e   araddr;
   } reg_req_t;

   typedef struct packed {
      logic        rvalid;
      logic [31:0] rdata;
   } reg_rsp_t;

   localparam int SPILL_SIZE_W = 8;
   localparam logic [SPILL_SIZE_W-1:0] SPILL_SIZE_RESET = 8'd4;

endpackage

// File: task_unit_regs.sv
`timescale 1ns/1ps

module task_unit_regs #(
   parameter int SPILL_THRESHOLD_RESET = 5,
   parameter int LOG_DEPTH             = 3
) (
   input  logic                                   clk,
   input  logic                                   rstn,
   input  task_unit_pkg::reg_req_t                reg_req,
   output task_unit_pkg::reg_rsp_t                reg_rsp,
   input  logic [LOG_DEPTH:0]                     n_tasks,
   input  logic                                   enq_fire,
   input  logic                                   coal_fire,
   input  logic                                   deq_fire,
   input  logic                                   splitter_fire,
   input  logic                                   overflow_fire,
   input  logic                                   deq_valid,
   output logic [LOG_DEPTH:0]                     spill_threshold,
   output logic [task_unit_pkg::SPILL_SIZE_W-1:0] spill_size
);
   import task_unit_pkg::*;

   logic [31:0] n_enq;
   logic [31:0] n_deq;
   logic [31:0] n_splitter_deq;
   logic [31:0] n_coal_child;
   logic [31:0] n_overflow;
   logic [31:0] n_cycles_deq_valid;

   // Programmable spill controls
   always_ff @(posedge clk) begin
      if (!rstn) begin
         spill_threshold <= (LOG_DEPTH+1)'(SPILL_THRESHOLD_RESET);
         spill_size      <= SPILL_SIZE_RESET;
      end else if (reg_req.wvalid) begin
         case (reg_req.waddr)
            REG_SPILL_THRESHOLD: spill_threshold <= reg_req.wdata[LOG_DEPTH:0];
            REG_SPILL_SIZE:      spill_size      <= reg_req.wdata[SPILL_SIZE_W-1:0];
            default:             ;
         endcase
      end
   end

   // Event counters
   always_ff @(posedge clk) begin
      if (!rstn) begin
         n_enq              <= '0;
         n_deq              <= '0;
         n_splitter_deq     <= '0;
         n_coal_child       <= '0;
         n_overflow         <= '0;
         n_cycles_deq_valid <= '0;
      end else begin
         if (enq_fire) begin
            n_enq <= n_enq + 1'b1;
         end
         if (deq_fire) begin
            n_deq <= n_deq + 1'b1;
         end
         if (splitter_fire) begin
            n_splitter_deq <= n_splitter_deq + 1'b1;
         end
         if (coal_fire) begin
            n_coal_child <= n_coal_child + 1'b1;
         end
         if (overflow_fire) begin
            n_overflow <= n_overflow + 1'b1;
         end
         // Counts stalled cycles too
         if (deq_valid) begin
            n_cycles_deq_valid <= n_cycles_deq_valid + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_rsp.rvalid <= 1'b0;
      end else begin
         reg_rsp.rvalid <= reg_req.arvalid;
      end
   end

   always_ff @(posedge clk) begin
      if (reg_req.arvalid) begin
         case (reg_req.araddr)
            REG_SPILL_THRESHOLD:         reg_rsp.rdata <= 32'(spill_threshold);
            REG_SPILL_SIZE:              reg_rsp.rdata <= 32'(spill_size);
            REG_N_TASKS:                 reg_rsp.rdata <= 32'(n_tasks);
            REG_STAT_N_ENQ:              reg_rsp.rdata <= n_enq;
            REG_STAT_N_DEQ:              reg_rsp.rdata <= n_deq;
            REG_STAT_N_SPLITTER_DEQ:     reg_rsp.rdata <= n_splitter_deq;
            REG_STAT_N_COAL_CHILD:       reg_rsp.rdata <= n_coal_child;
            REG_STAT_N_OVERFLOW:         reg_rsp.rdata <= n_overflow;
            REG_STAT_N_CYCLES_DEQ_VALID: reg_rsp.rdata <= n_cycles_deq_valid;
            default:                     reg_rsp.rdata <= '0;
         endcase
      end
   end

   // A threshold at or above the depth would let tile enqueues hit a full FIFO
   assert property (@(posedge clk) disable iff (!rstn)
      reg_req.wvalid && reg_req.waddr == REG_SPILL_THRESHOLD
         |-> reg_req.wdata < 32'(1 << LOG_DEPTH))
      else $error("task_unit_regs: spill threshold at or above FIFO depth");

endmodule

// File: tb_task_unit_table.svh
`ifndef TB_TASK_UNIT_TABLE_SVH
`define TB_TASK_UNIT_TABLE_SVH

typedef enum {OP_ENQ, OP_ENQ_REFUSED, OP_BOTH, OP_DRAIN, OP_WRITE, OP_READ} op_e;
typedef enum {PORT_NONE, PORT_DEQ, PORT_SPL, PORT_OVF} port_e;

typedef struct {
   string       name;
   op_e         op;
   bit          splitter;
   logic [2:0]  ready;
   reg_addr_e   addr;
   logic [31:0] value;
   port_e       port;
   bit          from_model;
} row_t;

localparam int N_ROWS = 48;

// Columns: name, op, splitter, ready {ovf, spl, deq}, address, value, port, from model
row_t stim [N_ROWS] = '{
   '{"reset threshold",  OP_READ,        0, 3'b000, REG_SPILL_THRESHOLD, 5, PORT_NONE, 0},
   '{"reset spill size", OP_READ,        0, 3'b000, REG_SPILL_SIZE,      4, PORT_NONE, 0},
   '{"reset occupancy",  OP_READ,        0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"order enq 0",      OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"order enq 1",      OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"order enq 2",      OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"order occupancy",  OP_READ,        0, 3'b000, REG_N_TASKS,         3, PORT_NONE, 0},
   '{"order deq 0",      OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_DEQ,  0},
   '{"order deq 1",      OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_DEQ,  0},
   '{"order deq 2",      OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_DEQ,  0},
   '{"steer enq split",  OP_ENQ,         1, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"steer enq work",   OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"steer split out",  OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_SPL,  0},
   '{"steer work out",   OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_DEQ,  0},
   '{"priority both",    OP_BOTH,        0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"priority out",     OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_DEQ,  0},
   '{"spill fill 0",     OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"spill fill 1",     OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"spill fill 2",     OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"spill fill 3",     OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"spill fill 4",     OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"spill fill 5",     OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"spill refused",    OP_ENQ_REFUSED, 0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"spill occupancy",  OP_READ,        0, 3'b000, REG_N_TASKS,         6, PORT_NONE, 0},
   '{"spill ovf 0",      OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_OVF,  0},
   '{"spill ovf 1",      OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_OVF,  0},
   '{"spill ovf 2",      OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_OVF,  0},
   '{"spill ovf 3",      OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_OVF,  0},
   '{"spill resume 0",   OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_DEQ,  0},
   '{"spill resume 1",   OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_DEQ,  0},
   '{"prog write thr",   OP_WRITE,       0, 3'b000, REG_SPILL_THRESHOLD, 2, PORT_NONE, 0},
   '{"prog write size",  OP_WRITE,       0, 3'b000, REG_SPILL_SIZE,      2, PORT_NONE, 0},
   '{"prog read thr",    OP_READ,        0, 3'b000, REG_SPILL_THRESHOLD, 2, PORT_NONE, 0},
   '{"prog read size",   OP_READ,        0, 3'b000, REG_SPILL_SIZE,      2, PORT_NONE, 0},
   '{"prog fill 0",      OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"prog fill 1",      OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"prog fill 2",      OP_ENQ,         0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"prog refused",     OP_ENQ_REFUSED, 0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 0},
   '{"prog ovf 0",       OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_OVF,  0},
   '{"prog ovf 1",       OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_OVF,  0},
   '{"prog resume",      OP_DRAIN,       0, 3'b111, REG_N_TASKS,         0, PORT_DEQ,  0},
   '{"stat enq",         OP_READ,        0, 3'b000, REG_STAT_N_ENQ,      0, PORT_NONE, 1},
   '{"stat deq",         OP_READ,        0, 3'b000, REG_STAT_N_DEQ,      0, PORT_NONE, 1},
   '{"stat splitter",    OP_READ,        0, 3'b000, REG_STAT_N_SPLITTER_DEQ, 0, PORT_NONE, 1},
   '{"stat coal child",  OP_READ,        0, 3'b000, REG_STAT_N_COAL_CHILD, 0, PORT_NONE, 1},
   '{"stat overflow",    OP_READ,        0, 3'b000, REG_STAT_N_OVERFLOW, 0, PORT_NONE, 1},
   '{"stat deq cycles",  OP_READ,        0, 3'b000, REG_STAT_N_CYCLES_DEQ_VALID, 0, PORT_NONE, 1},
   '{"stat occupancy",   OP_READ,        0, 3'b000, REG_N_TASKS,         0, PORT_NONE, 1}
};

`endif

// File: tb_task_unit.sv
`timescale 1ns/1ps

module tb_task_unit;
   import task_unit_pkg::*;

   `include "tb_task_unit_table.svh"

   localparam int THRESHOLD_RESET = 5;
   localparam int DEPTH           = 8;
   localparam int TIMEOUT         = 50;

   logic     clk;
   logic     rstn;
   logic     task_enq_valid;
   logic     task_enq_ready;
   task_t    task_enq_data;
   logic     coal_child_valid;
   logic     coal_child_ready;
   task_t    coal_child_data;
   logic     overflow_valid;
   logic     overflow_ready;
   task_t    overflow_data;
   logic     task_deq_valid;
   logic     task_deq_ready;
   task_t    task_deq_data;
   logic     splitter_deq_valid;
   logic     splitter_deq_ready;
   task_t    splitter_deq_task;
   logic     full;
   logic     almost_full;
   logic     empty;
   reg_req_t reg_req;
   reg_rsp_t reg_rsp;

   integer seed   = 46574;
   int     errors = 0;
   string  cur_name = "reset";

   // Reference queue and spill state
   task_t       model_q[$];
   int          model_thr;
   int          model_size;
   int          model_rem;
   int          n_enq;
   int          n_deq;
   int          n_spl;
   int          n_coal;
   int          n_ovf;
   int          n_deq_valid;
   logic [31:0] exp_rdata;

   task_unit task_unit_i (
      .clk                (clk),
      .rstn               (rstn),
      .task_enq_valid     (task_enq_valid),
      .task_enq_ready     (task_enq_ready),
      .task_enq_data      (task_enq_data),
      .coal_child_valid   (coal_child_valid),
      .coal_child_ready   (coal_child_ready),
      .coal_child_data    (coal_child_data),
      .overflow_valid     (overflow_valid),
      .overflow_ready     (overflow_ready),
      .overflow_data      (overflow_data),
      .task_deq_valid     (task_deq_valid),
      .task_deq_ready     (task_deq_ready),
      .task_deq_data      (task_deq_data),
      .splitter_deq_valid (splitter_deq_valid),
      .splitter_deq_ready (splitter_deq_ready),
      .splitter_deq_task  (splitter_deq_task),
      .full               (full),
      .almost_full        (almost_full),
      .empty              (empty),
      .reg_req            (reg_req),
      .reg_rsp            (reg_rsp)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   task automatic stop_with_failure();
      errors++;
      $display("CHECKS FAILED");
      $fatal(1, "Stopping at the first error");
   endtask

   task automatic check_value(input string name, input logic [127:0] exp,
                              input logic [127:0] act);
      if (exp !== act) begin
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic report_timeout(input string name, input string what);
      $display("Timeout in %s: %s within %0d cycles", name, what, TIMEOUT);
      stop_with_failure();
   endtask

   function automatic task_t random_task(input bit splitter);
      task_t t;
      t.ttype  = splitter ? TASK_TYPE_SPLITTER : TASK_TYPE_WORK;
      t.ts     = $random(seed);
      t.locale = $random(seed);
      t.args   = $random(seed);
      return t;
   endfunction

   // Scoreboard sampling pre-edge values at every rising edge
   always @(posedge clk) begin
      int n;
      bit exp_ovf;
      bit exp_spl;
      bit exp_deq;
      bit exp_coal_rdy;
      bit exp_enq_rdy;
      if (!rstn) begin
         model_q.delete();
         model_thr   = THRESHOLD_RESET;
         model_size  = SPILL_SIZE_RESET;
         model_rem   = 0;
         n_enq       = 0;
         n_deq       = 0;
         n_spl       = 0;
         n_coal      = 0;
         n_ovf       = 0;
         n_deq_valid = 0;
      end else begin
         n            = model_q.size();
         exp_ovf      = (n != 0) && (model_rem != 0);
         exp_spl      = (n != 0) && (model_rem == 0) && (model_q[0].ttype == TASK_TYPE_SPLITTER);
         exp_deq      = (n != 0) && (model_rem == 0) && !exp_spl;
         exp_coal_rdy = coal_child_valid && (n < DEPTH);
         exp_enq_rdy  = task_enq_valid && !exp_coal_rdy && !(n > model_thr);
         check_value({cur_name, " overflow_valid"}, exp_ovf, overflow_valid);
         check_value({cur_name, " splitter_deq_valid"}, exp_spl, splitter_deq_valid);
         check_value({cur_name, " task_deq_valid"}, exp_deq, task_deq_valid);
         check_value({cur_name, " coal_child_ready"}, exp_coal_rdy, coal_child_ready);
         check_value({cur_name, " task_enq_ready"}, exp_enq_rdy, task_enq_ready);
         check_value({cur_name, " almost_full"}, n > model_thr, almost_full);
         check_value({cur_name, " empty"}, n == 0, empty);
         check_value({cur_name, " full"}, n == DEPTH, full);
         if (reg_req.arvalid) begin
            case (reg_req.araddr)
               REG_SPILL_THRESHOLD:         exp_rdata = model_thr;
               REG_SPILL_SIZE:              exp_rdata = model_size;
               REG_N_TASKS:                 exp_rdata = n;
               REG_STAT_N_ENQ:              exp_rdata = n_enq;
               REG_STAT_N_DEQ:              exp_rdata = n_deq;
               REG_STAT_N_SPLITTER_DEQ:     exp_rdata = n_spl;
               REG_STAT_N_COAL_CHILD:       exp_rdata = n_coal;
               REG_STAT_N_OVERFLOW:         exp_rdata = n_ovf;
               REG_STAT_N_CYCLES_DEQ_VALID: exp_rdata = n_deq_valid;
               default:                     exp_rdata = '0;
            endcase
         end
         if (exp_ovf && overflow_ready) begin
            check_value({cur_name, " overflow_data"}, model_q[0], overflow_data);
            void'(model_q.pop_front());
            n_ovf++;
         end else if (exp_spl && splitter_deq_ready) begin
            check_value({cur_name, " splitter_deq_task"}, model_q[0], splitter_deq_task);
            void'(model_q.pop_front());
            n_spl++;
         end else if (exp_deq && task_deq_ready) begin
            check_value({cur_name, " task_deq_data"}, model_q[0], task_deq_data);
            void'(model_q.pop_front());
            n_deq++;
         end
         if (exp_deq) begin
            n_deq_valid++;
         end
         // Spill count loads only when idle and above threshold
         if (model_rem == 0 && n > model_thr) begin
            model_rem = model_size;
         end else if (exp_ovf && overflow_ready) begin
            model_rem--;
         end
         if (exp_coal_rdy) begin
            model_q.push_back(coal_child_data);
            n_coal++;
         end else if (exp_enq_rdy) begin
            model_q.push_back(task_enq_data);
            n_enq++;
         end
         if (reg_req.wvalid && reg_req.waddr == REG_SPILL_THRESHOLD) begin
            model_thr = reg_req.wdata;
         end
         if (reg_req.wvalid && reg_req.waddr == REG_SPILL_SIZE) begin
            model_size = reg_req.wdata[SPILL_SIZE_W-1:0];
         end
      end
   end

   task automatic apply_row(input row_t r);
      int    cycles;
      bit    done;
      port_e got;
      @(negedge clk);
      cur_name         = r.name;
      task_enq_valid   = 1'b0;
      coal_child_valid = 1'b0;
      reg_req.wvalid   = 1'b0;
      reg_req.arvalid  = 1'b0;
      {overflow_ready, splitter_deq_ready, task_deq_ready} = r.ready;
      done = 1'b0;
      case (r.op)
         OP_ENQ: begin
            task_enq_valid = 1'b1;
            task_enq_data  = random_task(r.splitter);
            for (cycles = 0; cycles < TIMEOUT && !done; cycles++) begin
               @(posedge clk);
               done = task_enq_ready;
            end
            if (!done) report_timeout(r.name, "tile enqueue port never became ready");
         end
         OP_ENQ_REFUSED: begin
            task_enq_valid = 1'b1;
            task_enq_data  = random_task(1'b0);
            @(posedge clk);
            check_value({r.name, " task_enq_ready"}, 1'b0, task_enq_ready);
         end
         OP_BOTH: begin
            coal_child_valid = 1'b1;
            coal_child_data  = random_task(1'b0);
            task_enq_valid   = 1'b1;
            task_enq_data    = random_task(1'b0);
            @(posedge clk);
            check_value({r.name, " coal_child_ready"}, 1'b1, coal_child_ready);
            check_value({r.name, " task_enq_ready"}, 1'b0, task_enq_ready);
         end
         OP_DRAIN: begin
            got = PORT_NONE;
            for (cycles = 0; cycles < TIMEOUT && got == PORT_NONE; cycles++) begin
               @(posedge clk);
               if (overflow_valid && overflow_ready) got = PORT_OVF;
               else if (splitter_deq_valid && splitter_deq_ready) got = PORT_SPL;
               else if (task_deq_valid && task_deq_ready) got = PORT_DEQ;
            end
            if (got == PORT_NONE) report_timeout(r.name, "no output port transferred a task");
            check_value({r.name, " port"}, r.port, got);
         end
         OP_WRITE: begin
            reg_req.wvalid = 1'b1;
            reg_req.waddr  = r.addr;
            reg_req.wdata  = r.value;
            @(posedge clk);
         end
         default: begin
            reg_req.arvalid = 1'b1;
            reg_req.araddr  = r.addr;
            for (cycles = 0; cycles < TIMEOUT && !done; cycles++) begin
               @(negedge clk);
               reg_req.arvalid = 1'b0;
               done = reg_rsp.rvalid;
            end
            if (!done) report_timeout(r.name, "register port never returned rvalid");
            // Answer is due exactly one cycle after the request
            check_value({r.name, " read latency"}, 1, cycles);
            check_value(r.name, r.from_model ? exp_rdata : r.value, reg_rsp.rdata);
         end
      endcase
   endtask

   initial begin
      rstn               = 1'b0;
      task_enq_valid     = 1'b0;
      task_enq_data      = '0;
      coal_child_valid   = 1'b0;
      coal_child_data    = '0;
      overflow_ready     = 1'b0;
      task_deq_ready     = 1'b0;
      splitter_deq_ready = 1'b0;
      reg_req            = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      @(negedge clk);
      check_value("reset empty", 1'b1, empty);
      check_value("reset almost_full", 1'b0, almost_full);
      check_value("reset valids", 3'b000,
                  {overflow_valid, splitter_deq_valid, task_deq_valid});
      check_value("reset rvalid", 1'b0, reg_rsp.rvalid);
      foreach (stim[i]) begin
         apply_row(stim[i]);
      end
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+.
task_unit_pkg.sv
task_fifo.sv
task_dispatch.sv
task_unit_regs.sv
task_unit.sv
tb_task_unit.sv
